//--- verilog/sccb_defines.svh
`ifndef SCCB_DEFINES_SVH
`define SCCB_DEFINES_SVH

// system clocks per scl half period
`define SCCB_HALF_DIV 500

// system clocks per quarter of the scl period
`define SCCB_QUARTER_DIV 250

// start condition setup and hold, in system clocks
`define SCCB_SETUP_CYCLES 60

// first scl low after the start hold
`define SCCB_TLOW_CYCLES 130

// one bus byte, msb first on the wire
`define SCCB_BYTE_W 8

// ov7670 write address
`define SCCB_DEVICE_ID 8'h42

`endif

//--- verilog/sccb_pkg.sv
package sccb_pkg;

    // write engine states, one byte walk reused for all three bytes
    typedef enum logic [4:0] {
        ST_IDLE,
        ST_START_SETUP,
        ST_START_HOLD,
        ST_FIRST_LOW,
        ST_BIT_Q1,
        ST_BIT_Q2,
        ST_BIT_Q3,
        ST_BIT_Q4,
        ST_ACK_LOW,
        ST_ACK_HIGH,
        ST_STOP_1,
        ST_STOP_2,
        ST_STOP_3,
        ST_DONE
    } engine_state_t;

    // scl level plus the double-rate flag names one quarter
    typedef struct packed {
        logic scl_level;
        logic quarter;
    } phase_t;

    // the four quarters of one scl period, in time order
    localparam phase_t PH_LOW_1  = '{scl_level: 1'b0, quarter: 1'b0};
    localparam phase_t PH_LOW_2  = '{scl_level: 1'b0, quarter: 1'b1};
    localparam phase_t PH_HIGH_1 = '{scl_level: 1'b1, quarter: 1'b0};
    localparam phase_t PH_HIGH_2 = '{scl_level: 1'b1, quarter: 1'b1};

endpackage

//--- verilog/ov7670_pkg.sv
`include "sccb_defines.svh"

package ov7670_pkg;

    // table entries, end marker included
    localparam int TABLE_LEN = 76;

    // raw value that closes the table
    localparam logic [15:0] END_MARKER = 16'hFFFF;

    typedef logic [6:0] index_t;

    // one table word, either compared whole or split into the two bus bytes
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [`SCCB_BYTE_W-1:0] reg_addr;
            logic [`SCCB_BYTE_W-1:0] data;
        } fields;
    } reg_word_t;

    // register address in the high byte, value in the low byte
    function automatic reg_word_t reg_entry(input index_t idx);
        reg_word_t w;
        case (idx)
            // soft reset, then rgb output setup
            7'd0:  w.raw = 16'h1280;
            7'd1:  w.raw = 16'hFFF0;
            7'd2:  w.raw = 16'h1214;
            7'd3:  w.raw = 16'h1180;
            7'd4:  w.raw = 16'h0C04;
            7'd5:  w.raw = 16'h3E19;
            7'd6:  w.raw = 16'h0400;
            7'd7:  w.raw = 16'h40D0;
            7'd8:  w.raw = 16'h3A04;
            7'd9:  w.raw = 16'h1418;
            // color matrix
            7'd10: w.raw = 16'h4FB3;
            7'd11: w.raw = 16'h50B3;
            7'd12: w.raw = 16'h5100;
            7'd13: w.raw = 16'h523D;
            7'd14: w.raw = 16'h53A7;
            7'd15: w.raw = 16'h54E4;
            7'd16: w.raw = 16'h589E;
            7'd17: w.raw = 16'h3DC0;
            // window and timing
            7'd18: w.raw = 16'h1715;
            7'd19: w.raw = 16'h1803;
            7'd20: w.raw = 16'h3200;
            7'd21: w.raw = 16'h1903;
            7'd22: w.raw = 16'h1A7B;
            7'd23: w.raw = 16'h0300;
            7'd24: w.raw = 16'h0F41;
            7'd25: w.raw = 16'h1E00;
            7'd26: w.raw = 16'h330B;
            7'd27: w.raw = 16'h3C78;
            7'd28: w.raw = 16'h6900;
            7'd29: w.raw = 16'h7400;
            7'd30: w.raw = 16'hB084;
            7'd31: w.raw = 16'hB10C;
            7'd32: w.raw = 16'hB20E;
            7'd33: w.raw = 16'hB380;
            // scaling
            7'd34: w.raw = 16'h703A;
            7'd35: w.raw = 16'h7135;
            7'd36: w.raw = 16'h7211;
            7'd37: w.raw = 16'h73F1;
            7'd38: w.raw = 16'hA202;
            // gamma curve
            7'd39: w.raw = 16'h7A20;
            7'd40: w.raw = 16'h7B10;
            7'd41: w.raw = 16'h7C1E;
            7'd42: w.raw = 16'h7D35;
            7'd43: w.raw = 16'h7E5A;
            7'd44: w.raw = 16'h7F69;
            7'd45: w.raw = 16'h8076;
            7'd46: w.raw = 16'h8180;
            7'd47: w.raw = 16'h8288;
            7'd48: w.raw = 16'h838F;
            7'd49: w.raw = 16'h8496;
            7'd50: w.raw = 16'h85A3;
            7'd51: w.raw = 16'h86AF;
            7'd52: w.raw = 16'h87C4;
            7'd53: w.raw = 16'h88D7;
            7'd54: w.raw = 16'h89E8;
            // agc, aec and white balance
            7'd55: w.raw = 16'h13E0;
            7'd56: w.raw = 16'h0000;
            7'd57: w.raw = 16'h1000;
            7'd58: w.raw = 16'h0D40;
            7'd59: w.raw = 16'h1418;
            7'd60: w.raw = 16'hA505;
            7'd61: w.raw = 16'hAB07;
            7'd62: w.raw = 16'h2495;
            7'd63: w.raw = 16'h2533;
            7'd64: w.raw = 16'h26E3;
            7'd65: w.raw = 16'h9F78;
            7'd66: w.raw = 16'hA068;
            7'd67: w.raw = 16'hA103;
            7'd68: w.raw = 16'hA6D8;
            7'd69: w.raw = 16'hA7D8;
            7'd70: w.raw = 16'hA8F0;
            7'd71: w.raw = 16'hA990;
            7'd72: w.raw = 16'hAA94;
            7'd73: w.raw = 16'h13E7;
            7'd74: w.raw = 16'h6907;
            // past the end reads as the marker too
            default: w.raw = END_MARKER;
        endcase
        return w;
    endfunction

endpackage

//--- verilog/sccb_req_if.sv
`timescale 1ns/10ps
`include "sccb_defines.svh"

// one write request, sequencer to engine
interface sccb_req_if;
    // one-cycle pulse, only while the engine idles
    logic                    start;
    // held from start until done
    logic [`SCCB_BYTE_W-1:0] reg_addr;
    logic [`SCCB_BYTE_W-1:0] data;
    // one-cycle pulse after the stop
    logic                    done;

    modport requester (output start, output reg_addr, output data, input done);

    modport engine (input start, input reg_addr, input data, output done);

endinterface

//--- verilog/sccb_phase_gen.sv
`timescale 1ns/10ps
`include "sccb_defines.svh"

module sccb_phase_gen (
    input  logic clk,
    input  logic reset,
    output logic scl_level,
    output logic quarter
);
    localparam int DIV_W = $clog2(`SCCB_HALF_DIV);

    logic [DIV_W-1:0] half_cnt;
    logic [DIV_W-1:0] quarter_cnt;
    sccb_pkg::phase_t phase_q;

    // both dividers free-run from zero, so their edges line up
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            half_cnt    <= '0;
            quarter_cnt <= '0;
            phase_q     <= '0;
        end else begin
            // scl level, one toggle per half period
            if (half_cnt == DIV_W'(`SCCB_HALF_DIV - 1)) begin
                half_cnt          <= '0;
                phase_q.scl_level <= ~phase_q.scl_level;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
            // quarter flag at twice the scl rate
            if (quarter_cnt == DIV_W'(`SCCB_QUARTER_DIV - 1)) begin
                quarter_cnt     <= '0;
                phase_q.quarter <= ~phase_q.quarter;
            end else begin
                quarter_cnt <= quarter_cnt + 1'b1;
            end
        end
    end

    assign scl_level = phase_q.scl_level;
    assign quarter   = phase_q.quarter;

    // scl edges must fall on quarter boundaries or the engine misreads phases
    a_phase_aligned: assert property (@(posedge clk) disable iff (reset)
        $changed(phase_q.scl_level) |-> $changed(phase_q.quarter));

endmodule

//--- verilog/sccb_write_engine.sv
`timescale 1ns/10ps
`include "sccb_defines.svh"

module sccb_write_engine (
    input  logic       clk,
    input  logic       reset,
    input  logic       scl_level,
    input  logic       quarter,
    sccb_req_if.engine req,
    output logic       scl,
    output logic       sda
);
    localparam int BIT_W = $clog2(`SCCB_BYTE_W);
    // bit position in the low bits, byte number above
    localparam int CNT_W = BIT_W + 2;
    localparam int CYC_W = $clog2(`SCCB_TLOW_CYCLES + 1);

    sccb_pkg::engine_state_t state;
    sccb_pkg::engine_state_t state_next;
    sccb_pkg::phase_t        phase;
    logic [CNT_W-1:0]        bit_cnt;
    logic [CNT_W-1:0]        bit_cnt_next;
    logic [`SCCB_BYTE_W-1:0] shift;
    logic [`SCCB_BYTE_W-1:0] shift_next;
    logic [CYC_W-1:0]        cyc_cnt;
    logic [CYC_W-1:0]        cyc_cnt_next;
    logic                    sda_en;
    logic                    sda_en_next;
    logic                    sda_out;
    logic                    sda_out_next;
    logic                    scl_follow;
    logic                    scl_follow_next;
    logic                    sda_line;
    logic                    in_start_stop;

    assign phase = '{scl_level: scl_level, quarter: quarter};

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state      <= sccb_pkg::ST_IDLE;
            bit_cnt    <= '0;
            cyc_cnt    <= '0;
            sda_en     <= 1'b1;
            sda_out    <= 1'b1;
            scl_follow <= 1'b0;
        end else begin
            state      <= state_next;
            bit_cnt    <= bit_cnt_next;
            cyc_cnt    <= cyc_cnt_next;
            sda_en     <= sda_en_next;
            sda_out    <= sda_out_next;
            scl_follow <= scl_follow_next;
        end
    end

    always_ff @(posedge clk) begin
        shift <= shift_next;
    end

    always_comb begin
        state_next      = state;
        bit_cnt_next    = bit_cnt;
        shift_next      = shift;
        cyc_cnt_next    = cyc_cnt;
        sda_en_next     = sda_en;
        sda_out_next    = sda_out;
        scl_follow_next = scl_follow;
        case (state)
            sccb_pkg::ST_IDLE: begin
                // bus parked, scl and sda high
                bit_cnt_next    = '0;
                cyc_cnt_next    = '0;
                sda_en_next     = 1'b1;
                sda_out_next    = 1'b1;
                scl_follow_next = 1'b0;
                if (req.start) begin
                    shift_next = `SCCB_DEVICE_ID;
                    state_next = sccb_pkg::ST_START_SETUP;
                end
            end
            sccb_pkg::ST_START_SETUP: begin
                if (cyc_cnt >= CYC_W'(`SCCB_SETUP_CYCLES - 1)) begin
                    // sda falls under high scl, the start condition
                    cyc_cnt_next = '0;
                    sda_out_next = 1'b0;
                    state_next   = sccb_pkg::ST_START_HOLD;
                end else begin
                    cyc_cnt_next = cyc_cnt + 1'b1;
                end
            end
            sccb_pkg::ST_START_HOLD: begin
                if (cyc_cnt < CYC_W'(`SCCB_SETUP_CYCLES - 1)) begin
                    cyc_cnt_next = cyc_cnt + 1'b1;
                end else if (phase == sccb_pkg::PH_LOW_1) begin
                    // join scl early in a low half so mid-low is still ahead
                    cyc_cnt_next    = '0;
                    scl_follow_next = 1'b1;
                    state_next      = sccb_pkg::ST_FIRST_LOW;
                end
            end
            sccb_pkg::ST_FIRST_LOW: begin
                if (cyc_cnt >= CYC_W'(`SCCB_TLOW_CYCLES - 1)) begin
                    cyc_cnt_next = '0;
                    state_next   = sccb_pkg::ST_BIT_Q1;
                end else begin
                    cyc_cnt_next = cyc_cnt + 1'b1;
                end
            end
            sccb_pkg::ST_BIT_Q1: begin
                // new bit in mid-low, msb first
                if (phase == sccb_pkg::PH_LOW_2) begin
                    sda_en_next  = 1'b1;
                    sda_out_next = shift[`SCCB_BYTE_W-1];
                    shift_next   = {shift[`SCCB_BYTE_W-2:0], 1'b0};
                    state_next   = sccb_pkg::ST_BIT_Q2;
                end
            end
            sccb_pkg::ST_BIT_Q2: begin
                if (phase == sccb_pkg::PH_HIGH_1) state_next = sccb_pkg::ST_BIT_Q3;
            end
            sccb_pkg::ST_BIT_Q3: begin
                if (phase == sccb_pkg::PH_HIGH_2) state_next = sccb_pkg::ST_BIT_Q4;
            end
            sccb_pkg::ST_BIT_Q4: begin
                // scl fell, bit done
                if (phase == sccb_pkg::PH_LOW_1) begin
                    bit_cnt_next = bit_cnt + 1'b1;
                    if (&bit_cnt[BIT_W-1:0]) state_next = sccb_pkg::ST_ACK_LOW;
                    else state_next = sccb_pkg::ST_BIT_Q1;
                end
            end
            sccb_pkg::ST_ACK_LOW: begin
                // ninth bit belongs to the camera
                sda_en_next = 1'b0;
                if (phase == sccb_pkg::PH_HIGH_1) state_next = sccb_pkg::ST_ACK_HIGH;
            end
            sccb_pkg::ST_ACK_HIGH: begin
                if (phase == sccb_pkg::PH_LOW_1) begin
                    // byte number picks what goes out next
                    case (bit_cnt[CNT_W-1:BIT_W])
                        2'd1: begin
                            shift_next = req.reg_addr;
                            state_next = sccb_pkg::ST_BIT_Q1;
                        end
                        2'd2: begin
                            shift_next = req.data;
                            state_next = sccb_pkg::ST_BIT_Q1;
                        end
                        default: state_next = sccb_pkg::ST_STOP_1;
                    endcase
                end
            end
            sccb_pkg::ST_STOP_1: begin
                // take sda low while scl is still low
                sda_en_next  = 1'b1;
                sda_out_next = 1'b0;
                if (phase == sccb_pkg::PH_HIGH_1) state_next = sccb_pkg::ST_STOP_2;
            end
            sccb_pkg::ST_STOP_2: begin
                // pin scl high from here on
                scl_follow_next = 1'b0;
                if (phase == sccb_pkg::PH_HIGH_2) state_next = sccb_pkg::ST_STOP_3;
            end
            sccb_pkg::ST_STOP_3: begin
                // sda rises under high scl, the stop condition
                sda_out_next = 1'b1;
                if (!phase.scl_level) state_next = sccb_pkg::ST_DONE;
            end
            sccb_pkg::ST_DONE: state_next = sccb_pkg::ST_IDLE;
            default: state_next = sccb_pkg::ST_IDLE;
        endcase
    end

    assign scl      = scl_follow ? scl_level : 1'b1;
    assign sda      = sda_en ? sda_out : 1'bz;
    assign req.done = (state == sccb_pkg::ST_DONE);

    // bus view with the pull-up resolving a released line
    assign sda_line      = sda_en ? sda_out : 1'b1;
    assign in_start_stop = state inside {sccb_pkg::ST_START_SETUP, sccb_pkg::ST_START_HOLD,
                                         sccb_pkg::ST_STOP_1, sccb_pkg::ST_STOP_2,
                                         sccb_pkg::ST_STOP_3};

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        req.done |=> !req.done);

    // data edges under high scl would read as start or stop
    a_sda_in_low: assert property (@(posedge clk) disable iff (reset)
        $changed(sda_line) && !in_start_stop |-> !scl);

endmodule

//--- verilog/ov7670_init_seq.sv
`timescale 1ns/10ps

module ov7670_init_seq (
    input  logic          clk,
    input  logic          reset,
    sccb_req_if.requester req,
    output logic          config_done
);
    ov7670_pkg::index_t    idx;
    ov7670_pkg::reg_word_t entry;
    logic                  pending;

    // table word for the write in flight, stable until done moves idx
    assign entry        = ov7670_pkg::reg_entry(idx);
    assign req.reg_addr = entry.fields.reg_addr;
    assign req.data     = entry.fields.data;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            idx         <= '0;
            pending     <= 1'b0;
            req.start   <= 1'b0;
            config_done <= 1'b0;
        end else begin
            req.start <= 1'b0;
            if (!pending && !config_done) begin
                // engine is idle whenever nothing is pending
                req.start <= 1'b1;
                pending   <= 1'b1;
            end else if (pending && req.done) begin
                pending <= 1'b0;
                idx     <= idx + 1'b1;
                // marker entry is written too, then the sequence stops
                if (entry.raw == ov7670_pkg::END_MARKER) begin
                    config_done <= 1'b1;
                end
            end
        end
    end

    // marker sits last, so the walk ends at the table length
    a_idx_range: assert property (@(posedge clk) disable iff (reset)
        idx <= ov7670_pkg::TABLE_LEN);

endmodule

//--- verilog/ov7670_sccb.sv
`timescale 1ns/10ps

module ov7670_sccb (
    input  logic clk,
    input  logic reset,
    output logic scl,
    output logic sda,
    output logic config_done
);
    // quarter-phase timing to the engine
    logic scl_level;
    logic quarter;

    // sequencer to engine request
    sccb_req_if req_if ();

    sccb_phase_gen sccb_phase_gen_i (
        .clk      (clk),
        .reset    (reset),
        .scl_level(scl_level),
        .quarter  (quarter)
    );

    sccb_write_engine sccb_write_engine_i (
        .clk      (clk),
        .reset    (reset),
        .scl_level(scl_level),
        .quarter  (quarter),
        .req      (req_if.engine),
        .scl      (scl),
        .sda      (sda)
    );

    ov7670_init_seq ov7670_init_seq_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req_if.requester),
        .config_done(config_done)
    );

endmodule

//--- bench/tb_ov7670_sccb.sv
`timescale 1ns/10ps
`include "sccb_defines.svh"

module tb_ov7670_sccb;
    // decoded bus events
    localparam int EV_START = 0;
    localparam int EV_STOP  = 1;
    localparam int EV_BIT   = 2;
    localparam int EV_NONE  = 3;
    // longest quiet stretch inside a write is about one scl period
    localparam int EVENT_TIMEOUT = 4 * `SCCB_HALF_DIV;
    // start, 27 bits, stop and slack in system clocks
    localparam int WRITE_CYCLES = 31 * 2 * `SCCB_HALF_DIV;
    localparam logic [7:0] ID_BYTE = 8'h42;

    logic clk;
    logic reset;
    wire  scl;
    wire  sda;
    wire  config_done;

    int checks;
    int errors;
    int err_mark;
    int mid_write;
    int check_from;
    int mid_delay;
    int mid_len;
    int n;
    bit abort;
    bit in_frame;
    logic prev_scl;
    logic prev_sda;
    int ev;
    logic ev_bit;

    // camera side pull-up lifts a released sda
    pullup (sda);

    ov7670_sccb ov7670_sccb_i (
        .clk        (clk),
        .reset      (reset),
        .scl        (scl),
        .sda        (sda),
        .config_done(config_done)
    );

    always #20 clk = ~clk;

    task automatic check_byte(input logic [`SCCB_BYTE_W-1:0] got,
                              input logic [`SCCB_BYTE_W-1:0] exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_entry(input ov7670_pkg::reg_word_t got,
                               input ov7670_pkg::reg_word_t exp, input int idx);
        checks++;
        if (got.raw !== exp.raw) begin
            errors++;
            $display("Mismatch reg_entry[%0d]: got %h expected %h", idx, got.raw, exp.raw);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // restart the decoder from the current line levels
    task automatic resync_bus();
        @(negedge clk);
        prev_scl = scl;
        prev_sda = sda;
        in_frame = 1'b0;
    endtask

    // lines sampled at the falling clk edge
    task automatic next_event(output int kind, output logic bit_val);
        int waited;
        logic cur_scl;
        logic cur_sda;
        kind    = EV_NONE;
        bit_val = 1'b0;
        waited  = 0;
        while (!abort && kind == EV_NONE) begin
            @(negedge clk);
            cur_scl = scl;
            cur_sda = sda;
            bit_val = cur_sda;
            // sda edges under high scl frame a write
            if (prev_scl && cur_scl && prev_sda && !cur_sda) begin
                kind     = EV_START;
                in_frame = 1'b1;
            end else if (prev_scl && cur_scl && !prev_sda && cur_sda) begin
                kind     = EV_STOP;
                in_frame = 1'b0;
            end else if (!prev_scl && cur_scl) begin
                kind = EV_BIT;
            end
            prev_scl = cur_scl;
            prev_sda = cur_sda;
            waited++;
            if (!in_frame && cur_scl !== 1'b1) begin
                $display("scl went low outside a write at %0t", $time);
                errors++;
                abort = 1'b1;
            end else if (kind == EV_NONE && waited >= EVENT_TIMEOUT) begin
                $display("no bus event within %0d cycles at %0t", EVENT_TIMEOUT, $time);
                errors++;
                abort = 1'b1;
            end
        end
    endtask

    task automatic read_write(input int idx, input bit full);
        int k;
        int i;
        int kind;
        logic b;
        logic [8:0] slot;
        logic [7:0] bytes [3];
        ov7670_pkg::reg_word_t got;
        if (abort) return;
        next_event(kind, b);
        if (!abort && kind != EV_START) begin
            $display("write %0d did not open with a start condition", idx);
            errors++;
            abort = 1'b1;
        end
        // id, address and data bytes with their ack slots
        for (k = 0; k < 3 && !abort; k++) begin
            for (i = 0; i < 9 && !abort; i++) begin
                next_event(kind, b);
                if (!abort && kind != EV_BIT) begin
                    $display("write %0d byte %0d cut short by a start or stop", idx, k);
                    errors++;
                    abort = 1'b1;
                end
                slot = {slot[7:0], b};
            end
            bytes[k] = slot[8:1];
            if (!abort) check_level(slot[0], 1'b1, "sda ack slot");
        end
        if (abort) return;
        // scl rises once more over a low sda, then sda rises
        next_event(kind, b);
        if (!abort) check_level(b, 1'b0, "sda before stop");
        if (!abort) next_event(kind, b);
        if (!abort && kind != EV_STOP) begin
            $display("write %0d did not end with a stop condition", idx);
            errors++;
            abort = 1'b1;
        end
        if (full && !abort) begin
            check_byte(bytes[0], ID_BYTE, "id byte");
            got.fields.reg_addr = bytes[1];
            got.fields.data     = bytes[2];
            check_entry(got, ov7670_pkg::reg_entry(ov7670_pkg::index_t'(idx)), idx);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        $display("test %-12s %s (%0d errors)", name,
                 (errors == mark) ? "ok" : "failed", errors - mark);
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        checks   = 0;
        errors   = 0;
        abort    = 1'b0;
        in_frame = 1'b0;
        prev_scl = 1'b1;
        prev_sda = 1'b1;
        void'($urandom(32'h20fa8140));
        // reset lands inside one of the first writes
        mid_write  = $urandom_range(3, 1);
        check_from = $urandom_range(mid_write - 1, 0);
        mid_delay  = $urandom_range(WRITE_CYCLES - 6000, 100);
        mid_len    = $urandom_range(8, 1);

        // power-on reset, then idle bus levels
        err_mark = errors;
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;
        resync_bus();
        check_level(scl, 1'b1, "scl");
        check_level(sda, 1'b1, "sda");
        check_level(config_done, 1'b0, "config_done");
        report_test("reset_levels", err_mark);

        // first writes with byte compares from check_from on
        err_mark = errors;
        for (n = 0; n < mid_write; n++) read_write(n, n >= check_from);
        report_test("early_writes", err_mark);

        // reset in the middle of the next write
        err_mark = errors;
        if (!abort) next_event(ev, ev_bit);
        if (!abort && ev != EV_START) begin
            $display("write %0d did not open with a start condition", mid_write);
            errors++;
            abort = 1'b1;
        end
        repeat (mid_delay) @(posedge clk);
        #2 reset = 1'b1;
        @(negedge clk);
        check_level(scl, 1'b1, "scl in reset");
        check_level(sda, 1'b1, "sda in reset");
        check_level(config_done, 1'b0, "config_done in reset");
        repeat (mid_len) @(posedge clk);
        #2 reset = 1'b0;
        resync_bus();
        report_test("mid_reset", err_mark);

        // whole table again from entry 0
        err_mark = errors;
        for (n = 0; n < ov7670_pkg::TABLE_LEN; n++) read_write(n, 1'b1);
        report_test("full_table", err_mark);

        // config_done rises, then the bus stays parked
        err_mark = errors;
        n = 0;
        while (!abort && config_done !== 1'b1 && n < EVENT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!abort && config_done !== 1'b1) begin
            $display("config_done stayed low after the last write");
            errors++;
            abort = 1'b1;
        end
        n = 0;
        while (!abort && n < 4 * WRITE_CYCLES) begin
            @(negedge clk);
            n++;
            if (scl !== 1'b1 || sda !== 1'b1 || config_done !== 1'b1) begin
                $display("bus left idle after config_done at %0t", $time);
                check_level(scl, 1'b1, "scl after config");
                check_level(sda, 1'b1, "sda after config");
                check_level(config_done, 1'b1, "config_done");
                abort = 1'b1;
            end
        end
        report_test("config_done", err_mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/sccb_pkg.sv
verilog/ov7670_pkg.sv
verilog/sccb_req_if.sv
verilog/sccb_phase_gen.sv
verilog/sccb_write_engine.sv
verilog/ov7670_init_seq.sv
verilog/ov7670_sccb.sv
bench/tb_ov7670_sccb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_ov7670_sccb \
    --Mdir obj_dir -o sim_tb > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
